// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
TOP        = tb_sdram_ctrl
FILELIST   = list.f
LOG        = sim.log
FAIL_MSG   = \*\* FAIL \*\*
PASS_MSG   = \*\* PASS \*\*

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/sdram_ctrl_chk.sv
`timescale 1ns/1ns

module sdram_ctrl_chk (
    input logic                  clk,
    input logic                  nreset,
    input sdram_pkg::sdram_cmd_t cmd,
    input logic                  cpu_req,
    input logic                  cpu_ack,
    input logic                  refresh_due
);
    import sdram_pkg::*;

    int due_cycles;

    always @(posedge clk) begin
        if (!nreset || !refresh_due)
            due_cycles <= 0;
        else
            due_cycles <= due_cycles + 1;
    end

    // every wait lasts at least two cycles, so a command follows two NOPs.
    assert property (@(posedge clk) disable iff (!nreset)
        (cmd != CMD_NOP) |-> ($past(cmd) == CMD_NOP && $past(cmd, 2) == CMD_NOP))
        else $error("command issued during a wait");

    assert property (@(posedge clk) disable iff (!nreset)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose without a request");

    assert property (@(posedge clk) disable iff (!nreset) due_cycles < 40)
        else $error("refresh stayed pending too long");

endmodule

bind sdram_ctrl_top sdram_ctrl_chk u_chk (
    .clk         (clk),
    .nreset      (nreset),
    .cmd         (sdram_cmd),
    .cpu_req     (cpu_req),
    .cpu_ack     (cpu_ack),
    .refresh_due (refresh_due)
);

// File: dv/sdram_model.sv
`timescale 1ns/1ns

module sdram_model (
    input  logic                   sdram_clk,
    input  sdram_pkg::sdram_cmd_t  cmd,
    input  sdram_pkg::sdram_addr_t address,
    input  sdram_pkg::bank_t       ba,
    input  sdram_pkg::mask_t       dqm,
    input  sdram_pkg::data_t       data_in,
    output sdram_pkg::data_t       data_out,
    output int                     errors,
    output int                     refresh_count,
    output logic                   init_done
);
    import sdram_pkg::*;

    data_t       mem [cpu_addr_t];
    sdram_addr_t open_row [4];
    int          init_step = 0;
    int          err_cnt = 0;
    int          ref_cnt = 0;
    data_t       rd_p1 = '0;
    data_t       rd_p2 = '0;
    data_t       rd_out = '0;

    assign errors        = err_cnt;
    assign refresh_count = ref_cnt;
    assign init_done     = (init_step == 4);
    assign data_out      = rd_out;

    // unwritten locations hold a pattern of their own address.
    function automatic data_t fill(cpu_addr_t a);
        return {a[10:0], a} ^ 32'h6d2b_91c4;
    endfunction

    always @(posedge sdram_clk) begin
        cpu_addr_t key;
        data_t     word;
        key = {ba, open_row[ba], address[COL_WIDTH-1:0]};
        rd_p2  <= rd_p1; // two stages give CAS latency 2.
        rd_out <= rd_p2;
        if (!cmd.ncs && init_step < 4) begin
            if ((init_step == 0 && !(cmd == CMD_PRECHARGE && address[10])) ||
                ((init_step == 1 || init_step == 2) && cmd != CMD_REFRESH) ||
                (init_step == 3 && !(cmd == CMD_LOAD_MODE && address == 11'h020))) begin
                err_cnt <= err_cnt + 1;
                $display("init order broken at step %0d, command %b", init_step, cmd);
            end
            init_step <= init_step + 1;
        end else if (!cmd.ncs) begin
            if (cmd == CMD_REFRESH)
                ref_cnt <= ref_cnt + 1;
            else if (cmd == CMD_ACTIVE)
                open_row[ba] <= address;
            else if (cmd == CMD_READ)
                rd_p1 <= mem.exists(key) ? mem[key] : fill(key);
            else if (cmd == CMD_WRITE) begin
                word = mem.exists(key) ? mem[key] : fill(key);
                for (int i = 0; i < NUM_BYTES; i++)
                    if (!dqm[i]) word[8*i +: 8] = data_in[8*i +: 8];
                mem[key] = word;
            end
        end
    end

endmodule

// File: dv/tb_sdram_ctrl.sv
`timescale 1ns/1ns

module tb_sdram_ctrl;
    import sdram_pkg::*;

    logic        clk;
    logic        nreset;
    cpu_addr_t   cpu_address;
    data_t       cpu_data_in;
    mask_t       cpu_nwr;
    logic        cpu_req;
    logic        cpu_ack;
    data_t       cpu_data_out;
    logic        sdram_clk;
    sdram_cmd_t  sdram_cmd;
    sdram_addr_t sdram_address;
    bank_t       sdram_ba;
    mask_t       sdram_dqm;
    data_t       sdram_data_out;
    data_t       sdram_data_in;
    int          model_errors;
    int          refresh_count;
    logic        init_done;

    integer      seed;
    int          errors;
    int          cycles;
    logic [7:0]  ref_mem [int];
    cpu_addr_t   addr_set [8];

    sdram_ctrl_top UUT (.*);

    sdram_model u_model (
        .sdram_clk (sdram_clk), .cmd (sdram_cmd), .address (sdram_address),
        .ba (sdram_ba), .dqm (sdram_dqm), .data_in (sdram_data_out),
        .data_out (sdram_data_in), .errors (model_errors),
        .refresh_count (refresh_count), .init_done (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!nreset)
            cycles <= 0;
        else
            cycles <= cycles + 1;
    end

    // the SDRAM content before any write is an address pattern.
    function automatic data_t expected_word(cpu_addr_t a);
        data_t w;
        data_t init;
        int    key;
        init = {a[10:0], a} ^ 32'h6d2b_91c4;
        for (int i = 0; i < NUM_BYTES; i++) begin
            key = (int'(a) << 2) + i;
            w[8*i +: 8] = ref_mem.exists(key) ? ref_mem[key] : init[8*i +: 8];
        end
        return w;
    endfunction

    // ********************
    // one CPU access
    // ********************
    task automatic access(input cpu_addr_t a, input data_t d, input mask_t m);
        int    t;
        int    hold;
        data_t exp;
        exp = expected_word(a);
        @(posedge clk);
        cpu_address <= a;
        cpu_data_in <= d;
        cpu_nwr     <= m;
        cpu_req     <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!cpu_ack && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (!cpu_ack) begin
            errors++;
            $display("timeout at %0t: no cpu_ack within 200 cycles", $time);
        end
        if (m == 4'hF && cpu_data_out !== exp) begin
            errors++;
            $display("ERROR %0t cpu_data_out: got %h expected %h", $time, cpu_data_out, exp);
        end else if (m != 4'hF) begin
            for (int i = 0; i < NUM_BYTES; i++)
                if (!m[i]) ref_mem[(int'(a) << 2) + i] = d[8*i +: 8];
        end
        // a slow CPU keeps the request up for a while after the ack.
        hold = $unsigned($random(seed)) % 8;
        repeat (hold) begin
            @(negedge clk);
            if (!cpu_ack) begin
                errors++;
                $display("cpu_ack fell at %0t while cpu_req was still high", $time);
            end
            if (sdram_cmd == CMD_ACTIVE) begin
                errors++;
                $display("a second access started at %0t while cpu_ack was high", $time);
            end
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        if (!cpu_ack) begin
            errors++;
            $display("cpu_ack fell at %0t before cpu_req was seen low", $time);
        end
        t = 0;
        while (cpu_ack && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (cpu_ack) begin
            errors++;
            $display("timeout at %0t: cpu_ack stayed high after cpu_req fell", $time);
        end
    endtask

    initial begin
        cpu_addr_t a;
        mask_t     m;
        seed        = 32'h76a6;
        nreset      = 1'b0;
        cpu_req     = 1'b0;
        cpu_address = '0;
        cpu_data_in = '0;
        cpu_nwr     = 4'hF;
        errors      = 0;
        repeat (16) @(posedge clk);
        nreset <= 1'b1;

        // full word write, then read back.
        a = cpu_addr_t'($random(seed));
        access(a, data_t'($random(seed)), 4'h0);
        access(a, '0, 4'hF);

        // masked writes merge into the stored word.
        a = cpu_addr_t'($random(seed));
        for (int i = 0; i < 6; i++) begin
            m = mask_t'($random(seed));
            if (m == 4'hF) m = 4'hE;
            access(a, data_t'($random(seed)), m);
            access(a, '0, 4'hF);
        end

        // i and i+4 share a bank with different rows.
        for (int i = 0; i < 8; i++) begin
            a = cpu_addr_t'($random(seed));
            a[CPU_ADDR_WIDTH-1 -: BANK_BITS] = bank_t'(i);
            a[COL_WIDTH] = i[2];
            addr_set[i] = a;
        end
        for (int n = 0; n < 300; n++) begin
            a = addr_set[$unsigned($random(seed)) % 8];
            m = ($random(seed) & 1) ? 4'hF : mask_t'($random(seed));
            access(a, data_t'($random(seed)), m);
        end

        if (!init_done) begin
            errors++;
            $display("the init sequence never completed");
        end
        if (refresh_count < cycles / REFRESH_PERIOD - 1) begin
            errors++;
            $display("ERROR %0t refresh_count: got %0d expected at least %0d", $time,
                     refresh_count, cycles / REFRESH_PERIOD - 1);
        end
        $display("errors: testbench %0d, model %0d", errors, model_errors);
        if (errors == 0 && model_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: hw/sdram_cmd_fsm.sv
`timescale 1ns/1ns

module sdram_cmd_fsm (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  cpu_req,
    input  sdram_pkg::mask_t      cpu_nwr,
    input  logic                  wait_done,
    input  logic                  refresh_due,
    output logic                  wait_load,
    output sdram_pkg::wait_t      wait_count,
    output logic                  refresh_done,
    output sdram_pkg::addr_sel_e  addr_sel,
    output sdram_pkg::sdram_cmd_t cmd,
    output logic                  capture,
    output logic                  cpu_ack
);
    import sdram_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic [1:0]  init_cnt;
    sdram_cmd_t  init_cmd;
    wait_t       init_wait;
    logic        is_read;
    logic        req;

    assign is_read = &cpu_nwr;          // no byte enabled means a read.
    assign req     = cpu_req & ~cpu_ack; // an acked request is not served again.

    // Init runs precharge-all, refresh, refresh, then load-mode.
    always_comb begin
        case (init_cnt)
            2'd3: begin
                init_cmd  = CMD_PRECHARGE;
                init_wait = wait_t'(PRECHARGE_LATENCY - 1);
            end
            2'd0: begin
                init_cmd  = CMD_LOAD_MODE;
                init_wait = wait_t'(AUTOREFRESH_LATENCY - 1);
            end
            default: begin
                init_cmd  = CMD_REFRESH;
                init_wait = wait_t'(AUTOREFRESH_LATENCY - 1);
            end
        endcase
    end

    // ********************
    // wait, address and capture control
    // ********************
    always_comb begin
        wait_load    = 1'b0;
        wait_count   = '0;
        refresh_done = 1'b0;
        addr_sel     = ADDR_ROW;
        capture      = 1'b0;
        case (state)
            ST_INIT: begin
                wait_load  = 1'b1;
                wait_count = init_wait;
                addr_sel   = (init_cnt == 2'd0) ? ADDR_MODE : ADDR_PRECHARGE_ALL;
            end
            ST_IDLE: begin
                if (refresh_due) begin
                    wait_load    = 1'b1;
                    wait_count   = wait_t'(AUTOREFRESH_LATENCY - 1);
                    refresh_done = 1'b1;
                end else if (req) begin
                    wait_load  = 1'b1;
                    wait_count = wait_t'(BANK_ACTIVATE_LATENCY - 1);
                end
            end
            ST_COL: begin
                wait_load  = 1'b1;
                wait_count = is_read ? wait_t'(CAS_LATENCY - 1) : wait_t'(PRECHARGE_LATENCY - 1);
                addr_sel   = ADDR_COL;
            end
            ST_READ: begin
                // the column command already started the precharge.
                wait_load  = 1'b1;
                wait_count = wait_t'(PRECHARGE_LATENCY - 1);
                capture    = 1'b1;
            end
            default: ;
        endcase
    end

    // ********************
    // state and command
    // ********************
    always_ff @(posedge clk) begin
        if (!nreset) begin
            state      <= ST_INIT;
            next_state <= ST_IDLE;
            init_cnt   <= 2'd3;
            cmd        <= CMD_NOP;
            cpu_ack    <= 1'b0;
        end else begin
            cmd <= CMD_NOP; // one cycle per command.
            case (state)
                ST_INIT: begin
                    cmd        <= init_cmd;
                    state      <= ST_WAIT;
                    next_state <= (init_cnt == 2'd0) ? ST_IDLE : ST_INIT;
                    init_cnt   <= init_cnt - 1'b1;
                end
                ST_IDLE: begin
                    if (!cpu_req)
                        cpu_ack <= 1'b0;
                    if (refresh_due) begin // refresh wins over a waiting request.
                        cmd        <= CMD_REFRESH;
                        state      <= ST_WAIT;
                        next_state <= ST_IDLE;
                    end else if (req) begin
                        cmd        <= CMD_ACTIVE;
                        state      <= ST_WAIT;
                        next_state <= ST_COL;
                    end
                end
                ST_WAIT: begin
                    if (wait_done)
                        state <= next_state;
                end
                ST_COL: begin
                    cmd        <= is_read ? CMD_READ : CMD_WRITE;
                    state      <= ST_WAIT;
                    next_state <= is_read ? ST_READ : ST_IDLE;
                    if (!is_read)
                        cpu_ack <= 1'b1; // write data goes out with the command.
                end
                ST_READ: begin
                    cpu_ack    <= 1'b1;
                    state      <= ST_WAIT;
                    next_state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/sdram_ctrl_top.sv
`timescale 1ns/1ns

module sdram_ctrl_top (
    input  logic                   clk,
    input  logic                   nreset,
    input  sdram_pkg::cpu_addr_t   cpu_address,
    input  sdram_pkg::data_t       cpu_data_in,
    input  sdram_pkg::mask_t       cpu_nwr,
    input  logic                   cpu_req,
    output logic                   cpu_ack,
    output sdram_pkg::data_t       cpu_data_out,
    output logic                   sdram_clk,
    output sdram_pkg::sdram_cmd_t  sdram_cmd,
    output sdram_pkg::sdram_addr_t sdram_address,
    output sdram_pkg::bank_t       sdram_ba,
    output sdram_pkg::mask_t       sdram_dqm,
    output sdram_pkg::data_t       sdram_data_out,
    input  sdram_pkg::data_t       sdram_data_in
);
    import sdram_pkg::*;

    logic      wait_load;
    wait_t     wait_count;
    logic      wait_done;
    logic      refresh_due;
    logic      refresh_done;
    addr_sel_e addr_sel;
    logic      capture;

    // the SDRAM samples on the middle of the controller cycle.
    assign sdram_clk = ~clk;

    sdram_timer u_timer (
        .clk          (clk),
        .nreset       (nreset),
        .wait_load    (wait_load),
        .wait_count   (wait_count),
        .refresh_done (refresh_done),
        .wait_done    (wait_done),
        .refresh_due  (refresh_due)
    );

    sdram_cmd_fsm u_fsm (
        .clk          (clk),
        .nreset       (nreset),
        .cpu_req      (cpu_req),
        .cpu_nwr      (cpu_nwr),
        .wait_done    (wait_done),
        .refresh_due  (refresh_due),
        .wait_load    (wait_load),
        .wait_count   (wait_count),
        .refresh_done (refresh_done),
        .addr_sel     (addr_sel),
        .cmd          (sdram_cmd),
        .capture      (capture),
        .cpu_ack      (cpu_ack)
    );

    sdram_datapath u_datapath (
        .clk            (clk),
        .cpu_address    (cpu_address),
        .cpu_data_in    (cpu_data_in),
        .cpu_nwr        (cpu_nwr),
        .addr_sel       (addr_sel),
        .capture        (capture),
        .sdram_data_in  (sdram_data_in),
        .sdram_address  (sdram_address),
        .sdram_ba       (sdram_ba),
        .sdram_dqm      (sdram_dqm),
        .sdram_data_out (sdram_data_out),
        .cpu_data_out   (cpu_data_out)
    );

endmodule

// File: hw/sdram_datapath.sv
`timescale 1ns/1ns

module sdram_datapath (
    input  logic                 clk,
    input  sdram_pkg::cpu_addr_t cpu_address,
    input  sdram_pkg::data_t     cpu_data_in,
    input  sdram_pkg::mask_t     cpu_nwr,
    input  sdram_pkg::addr_sel_e addr_sel,
    input  logic                 capture,
    input  sdram_pkg::data_t     sdram_data_in,
    output sdram_pkg::sdram_addr_t sdram_address,
    output sdram_pkg::bank_t     sdram_ba,
    output sdram_pkg::mask_t     sdram_dqm,
    output sdram_pkg::data_t     sdram_data_out,
    output sdram_pkg::data_t     cpu_data_out
);
    import sdram_pkg::*;

    bank_t                bank;
    logic [ROW_WIDTH-1:0] row;
    logic [COL_WIDTH-1:0] col;
    sdram_addr_t          addr_next;

    assign bank = cpu_address[CPU_ADDR_WIDTH-1 -: BANK_BITS];
    assign row  = cpu_address[COL_WIDTH +: ROW_WIDTH];
    assign col  = cpu_address[COL_WIDTH-1:0];

    // ********************
    // address mux
    // ********************
    always_comb begin
        case (addr_sel)
            ADDR_COL: begin
                addr_next = sdram_addr_t'(col);
                addr_next[AUTO_PRECHARGE_BIT] = 1'b1; // auto-precharge after the access.
            end
            ADDR_MODE:
                addr_next = sdram_addr_t'(MODE_REGISTER_VALUE);
            ADDR_PRECHARGE_ALL: begin
                addr_next = '0;
                addr_next[AUTO_PRECHARGE_BIT] = 1'b1;
            end
            default:
                addr_next = row;
        endcase
    end

    // Registered in step with the command from the state machine.
    always_ff @(posedge clk) begin
        sdram_address <= addr_next;
        sdram_ba      <= bank;
    end

    assign sdram_data_out = cpu_data_in;
    assign sdram_dqm      = cpu_nwr; // masks the disabled bytes of a write.

    always_ff @(posedge clk) begin
        if (capture)
            cpu_data_out <= sdram_data_in;
    end

endmodule

// File: hw/sdram_pkg.sv
package sdram_pkg;

    // ********************
    // widths and types
    // ********************
    localparam int DATA_WIDTH     = 32;
    localparam int NUM_BYTES      = DATA_WIDTH / 8;
    localparam int ROW_WIDTH      = 11;
    localparam int COL_WIDTH      = 8;
    localparam int BANK_BITS      = 2;
    localparam int CPU_ADDR_WIDTH = BANK_BITS + ROW_WIDTH + COL_WIDTH;

    localparam int AUTO_PRECHARGE_BIT = 10; // A10 selects auto-precharge and precharge-all.

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [NUM_BYTES-1:0]      mask_t;       // active low byte write enables.
    typedef logic [CPU_ADDR_WIDTH-1:0] cpu_addr_t;   // {bank, row, column}.
    typedef logic [ROW_WIDTH-1:0]      sdram_addr_t;
    typedef logic [BANK_BITS-1:0]      bank_t;

    // ********************
    // timing
    // ********************
    localparam int MODE_REGISTER_VALUE   = 'h20; // burst length 1, CAS latency 2.
    localparam int CAS_LATENCY           = 2;
    localparam int BANK_ACTIVATE_LATENCY = 2;
    localparam int PRECHARGE_LATENCY     = 2;
    localparam int AUTOREFRESH_LATENCY   = 3;
    localparam int REFRESH_PERIOD        = 256;
    localparam int WAIT_BITS             = 3;

    typedef logic [WAIT_BITS-1:0] wait_t;

    // All four command pins are active low.
    typedef struct packed {
        logic ncs;
        logic ras;
        logic cas;
        logic nwe;
    } sdram_cmd_t;

    // The NOP deselects the chip, which the SDRAM treats the same as a NOP.
    localparam sdram_cmd_t CMD_NOP       = '{ncs: 1'b1, ras: 1'b1, cas: 1'b1, nwe: 1'b1};
    localparam sdram_cmd_t CMD_ACTIVE    = '{ncs: 1'b0, ras: 1'b0, cas: 1'b1, nwe: 1'b1};
    localparam sdram_cmd_t CMD_READ      = '{ncs: 1'b0, ras: 1'b1, cas: 1'b0, nwe: 1'b1};
    localparam sdram_cmd_t CMD_WRITE     = '{ncs: 1'b0, ras: 1'b1, cas: 1'b0, nwe: 1'b0};
    localparam sdram_cmd_t CMD_REFRESH   = '{ncs: 1'b0, ras: 1'b0, cas: 1'b0, nwe: 1'b1};
    localparam sdram_cmd_t CMD_PRECHARGE = '{ncs: 1'b0, ras: 1'b0, cas: 1'b1, nwe: 1'b0};
    localparam sdram_cmd_t CMD_LOAD_MODE = '{ncs: 1'b0, ras: 1'b0, cas: 1'b0, nwe: 1'b0};

    typedef enum logic [1:0] {
        ADDR_ROW,
        ADDR_COL,
        ADDR_MODE,
        ADDR_PRECHARGE_ALL
    } addr_sel_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_WAIT,
        ST_COL,
        ST_READ
    } ctrl_state_e;

endpackage

// File: hw/sdram_timer.sv
`timescale 1ns/1ns

module sdram_timer (
    input  logic             clk,
    input  logic             nreset,
    input  logic             wait_load,
    input  sdram_pkg::wait_t wait_count,
    input  logic             refresh_done,
    output logic             wait_done,
    output logic             refresh_due
);
    import sdram_pkg::*;

    logic [$clog2(REFRESH_PERIOD)-1:0] refresh_cnt;
    wait_t wait_cnt;
    logic  wait_busy;

    // ********************
    // refresh interval
    // ********************
    always_ff @(posedge clk) begin
        if (!nreset) begin
            refresh_cnt <= '0;
            refresh_due <= 1'b0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1; // wraps every REFRESH_PERIOD cycles.
            if (refresh_cnt == REFRESH_PERIOD - 1)
                refresh_due <= 1'b1;
            else if (refresh_done)
                refresh_due <= 1'b0;
        end
    end

    // ********************
    // command wait
    // ********************
    always_ff @(posedge clk) begin
        if (!nreset) begin
            wait_cnt  <= '0;
            wait_busy <= 1'b0;
        end else if (wait_load) begin
            wait_cnt  <= wait_count;
            wait_busy <= 1'b1;
        end else if (wait_busy) begin
            if (wait_cnt == '0)
                wait_busy <= 1'b0;
            else
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign wait_done = wait_busy && (wait_cnt == '0); // last cycle of the wait.

endmodule

// File: list.f
hw/sdram_pkg.sv
hw/sdram_timer.sv
hw/sdram_cmd_fsm.sv
hw/sdram_datapath.sv
hw/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/sdram_ctrl_chk.sv
dv/tb_sdram_ctrl.sv
